// ==== logic/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// width of one data word on both buses
`define DC_DATA_WIDTH 32

// four ways
`define DC_WAY_BITS 2

// four sets
`define DC_INDEX_BITS 2

// four words per line, so a burst is always four beats long
`define DC_OFFSET_BITS 2

`endif

// ==== logic/dbus_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package dbus_pkg;

    // byte address from the processor, also used line-aligned on the memory bus
    typedef logic [31:0] addr_t;

    // one data word
    typedef logic [`DC_DATA_WIDTH - 1:0] word_t;

    // byte write mask, one bit per byte of a word
    typedef logic [`DC_DATA_WIDTH / 8 - 1:0] strobe_t;

endpackage

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package cache_pkg;

    // address fields above the byte bits
    typedef logic [$bits(dbus_pkg::addr_t) - `DC_INDEX_BITS - `DC_OFFSET_BITS
                   - $clog2(`DC_DATA_WIDTH / 8) - 1:0] tag_t;
    typedef logic [`DC_INDEX_BITS - 1:0] index_t;
    typedef logic [`DC_OFFSET_BITS - 1:0] offset_t;

    typedef logic [`DC_WAY_BITS - 1:0] way_t;

    // data array address, way then set then word
    typedef logic [`DC_WAY_BITS + `DC_INDEX_BITS + `DC_OFFSET_BITS - 1:0] pos_t;

    // tree pseudo-LRU, one bit per inner node
    typedef logic [(1 << `DC_WAY_BITS) - 2:0] tree_t;

    // word-arrived flags of the line under refill
    typedef logic [(1 << `DC_OFFSET_BITS) - 1:0] ready_t;

    typedef enum logic [1:0] {
        st_idle,
        st_refill,
        st_writeback
    } miss_state_t;

endpackage

`default_nettype wire

// ==== logic/refill_if.sv ====
`default_nettype none

interface refill_if ();

    // miss request from the lookup side
    logic               start;
    cache_pkg::tag_t    line_tag;
    cache_pkg::index_t  line_index;
    cache_pkg::way_t    victim_way;
    cache_pkg::tag_t    victim_tag;
    logic               victim_dirty;

    // refill progress from the engine
    logic               avail;
    logic               busy;
    cache_pkg::tag_t    cur_tag;
    cache_pkg::index_t  cur_index;
    cache_pkg::ready_t  ready;

    modport lookup (
        output start, line_tag, line_index, victim_way, victim_tag, victim_dirty,
        input  avail, busy, cur_tag, cur_index, ready
    );

    modport engine (
        input  start, line_tag, line_index, victim_way, victim_tag, victim_dirty,
        output avail, busy, cur_tag, cur_index, ready
    );

endinterface

`default_nettype wire

// ==== logic/ram_port_if.sv ====
`default_nettype none

interface ram_port_if ();

    logic               en;
    dbus_pkg::strobe_t  strobe;
    cache_pkg::pos_t    pos;
    dbus_pkg::word_t    wdata;
    dbus_pkg::word_t    rdata;
    // en delayed by one cycle, marks rdata as fresh
    logic               rvalid;

    modport user (
        output en, strobe, pos, wdata,
        input  rdata, rvalid
    );

    modport ram (
        input  en, strobe, pos, wdata,
        output rdata, rvalid
    );

endinterface

`default_nettype wire

// ==== logic/tag_lookup.sv ====
`default_nettype none

`include "dcache_defines.svh"

module tag_lookup (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     req,
    input  wire                     is_write,
    input  wire dbus_pkg::addr_t    addr,
    input  wire dbus_pkg::strobe_t  strobe,
    input  wire dbus_pkg::word_t    wdata,
    output logic                    addr_ok,
    refill_if.lookup                rf,
    ram_port_if.user                hit_port
);
    localparam int num_ways  = 1 << `DC_WAY_BITS;
    localparam int num_sets  = 1 << `DC_INDEX_BITS;
    localparam int byte_bits = $clog2(`DC_DATA_WIDTH / 8);

    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    // per-set storage
    cache_pkg::tag_t                        tag_ram [num_sets][num_ways];
    logic [num_sets - 1:0][num_ways - 1:0]  valid_bits;
    logic [num_sets - 1:0][num_ways - 1:0]  dirty_bits;
    cache_pkg::tree_t [num_sets - 1:0]      tree_bits;

    logic [num_ways - 1:0]  hit_vec;
    logic                   hit;
    cache_pkg::way_t        hit_way;
    cache_pkg::way_t        victim_way;
    cache_pkg::tree_t       cur_tree;
    cache_pkg::tree_t       next_tree;
    logic                   in_refill;
    logic                   word_ready;
    logic                   to_hit;
    logic                   to_miss;

    assign {req_tag, req_index, req_offset} = addr[$bits(addr) - 1:byte_bits];

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_bits[req_index][w] && tag_ram[req_index][w] == req_tag;
        end
    end

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // a set node bit points to the half holding the victim
    assign cur_tree   = tree_bits[req_index];
    assign victim_way = cur_tree[0] ? {1'b1, cur_tree[2]} : {1'b0, cur_tree[1]};

    // point both nodes on the path away from the used way
    always_comb begin
        next_tree    = cur_tree;
        next_tree[0] = ~hit_way[1];
        if (hit_way[1]) begin
            next_tree[2] = ~hit_way[0];
        end else begin
            next_tree[1] = ~hit_way[0];
        end
    end

    // the new tag is already installed, so the word itself must have arrived
    assign in_refill  = rf.busy && rf.cur_tag == req_tag && rf.cur_index == req_index;
    assign word_ready = !in_refill || rf.ready[req_offset];

    assign to_hit  = req && hit && word_ready;
    assign to_miss = req && !hit && rf.avail;
    assign addr_ok = to_hit;

    assign hit_port.en     = to_hit;
    assign hit_port.strobe = is_write ? strobe : '0;
    assign hit_port.pos    = {hit_way, req_index, req_offset};
    assign hit_port.wdata  = wdata;

    assign rf.start        = to_miss;
    assign rf.line_tag     = req_tag;
    assign rf.line_index   = req_index;
    assign rf.victim_way   = victim_way;
    assign rf.victim_tag   = tag_ram[req_index][victim_way];
    assign rf.victim_dirty = valid_bits[req_index][victim_way]
                             && dirty_bits[req_index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            tree_bits  <= '0;
        end else if (to_hit) begin
            tree_bits[req_index] <= next_tree;
            if (is_write) begin
                dirty_bits[req_index][hit_way] <= 1'b1;
            end
        end else if (to_miss) begin
            // new line starts clean, refill brings the memory copy
            valid_bits[req_index][victim_way] <= 1'b1;
            dirty_bits[req_index][victim_way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (to_miss) begin
            tag_ram[req_index][victim_way] <= req_tag;
        end
    end

    // a line is never present in two ways of a set
    assert property (@(posedge clk) disable iff (resetn) req |-> $onehot0(hit_vec));

    // the engine takes up a started miss on the next edge
    assert property (@(posedge clk) disable iff (resetn)
        rf.start |=> rf.busy && rf.cur_tag == $past(rf.line_tag));

endmodule

`default_nettype wire

// ==== logic/data_store.sv ====
`default_nettype none

module data_store (
    input  wire         clk,
    input  wire         resetn,
    ram_port_if.ram     hit_port,
    ram_port_if.ram     fill_port
);
    localparam int depth = 1 << $bits(cache_pkg::pos_t);

    dbus_pkg::word_t mem [depth];

    function automatic dbus_pkg::word_t merge_bytes(input dbus_pkg::word_t old_word,
                                                    input dbus_pkg::word_t new_word,
                                                    input dbus_pkg::strobe_t mask);
        dbus_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < $bits(dbus_pkg::strobe_t); b++) begin
            if (mask[b]) begin
                result[8 * b +: 8] = new_word[8 * b +: 8];
            end
        end
        return result;
    endfunction

    // both ports read first, the old word leaves on rdata
    always_ff @(posedge clk) begin
        if (hit_port.en) begin
            hit_port.rdata <= mem[hit_port.pos];
            if (|hit_port.strobe) begin
                mem[hit_port.pos] <= merge_bytes(mem[hit_port.pos], hit_port.wdata,
                                                 hit_port.strobe);
            end
        end
        if (fill_port.en) begin
            fill_port.rdata <= mem[fill_port.pos];
            if (|fill_port.strobe) begin
                mem[fill_port.pos] <= merge_bytes(mem[fill_port.pos], fill_port.wdata,
                                                  fill_port.strobe);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit_port.rvalid  <= 1'b0;
            fill_port.rvalid <= 1'b0;
        end else begin
            hit_port.rvalid  <= hit_port.en;
            fill_port.rvalid <= fill_port.en;
        end
    end

    // hits to the refill line only touch words already filled
    assert property (@(posedge clk) disable iff (resetn)
        !(hit_port.en && |hit_port.strobe && fill_port.en && |fill_port.strobe
          && hit_port.pos == fill_port.pos));

endmodule

`default_nettype wire

// ==== logic/miss_engine.sv ====
`default_nettype none

`include "dcache_defines.svh"

module miss_engine (
    input  wire                     clk,
    input  wire                     resetn,
    refill_if.engine                rf,
    ram_port_if.user                fill_port,
    output logic                    mem_valid,
    output logic                    mem_is_write,
    output dbus_pkg::addr_t         mem_addr,
    output dbus_pkg::word_t         mem_wdata,
    input  wire                     mem_okay,
    input  wire dbus_pkg::word_t    mem_rdata,
    input  wire                     mem_last
);
    localparam int words_per_line = 1 << `DC_OFFSET_BITS;
    localparam int low_bits       = `DC_OFFSET_BITS + $clog2(`DC_DATA_WIDTH / 8);

    cache_pkg::miss_state_t state;
    cache_pkg::tag_t        fill_tag;
    cache_pkg::index_t      fill_index;
    cache_pkg::way_t        fill_way;
    cache_pkg::tag_t        victim_tag;
    logic                   victim_dirty;
    cache_pkg::offset_t     offset;
    cache_pkg::ready_t      ready;

    // victim capture trails the fill write by one cycle
    logic                   cap_en;
    cache_pkg::offset_t     cap_offset;
    dbus_pkg::word_t        victim_buf [words_per_line];

    logic                   fill_write;
    logic                   burst_end;

    assign fill_write = state == cache_pkg::st_refill && mem_okay;
    assign burst_end  = mem_okay && mem_last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= cache_pkg::st_idle;
            offset <= '0;
            ready  <= '0;
            cap_en <= 1'b0;
        end else begin
            cap_en <= 1'b0;
            case (state)
                cache_pkg::st_refill: begin
                    if (mem_okay) begin
                        ready[offset] <= 1'b1;
                        offset        <= cache_pkg::offset_t'(offset + 1'b1);
                        cap_en        <= 1'b1;
                        cap_offset    <= offset;
                        if (mem_last) begin
                            state <= victim_dirty ? cache_pkg::st_writeback
                                                  : cache_pkg::st_idle;
                        end
                    end
                end
                cache_pkg::st_writeback: begin
                    if (mem_okay) begin
                        offset <= cache_pkg::offset_t'(offset + 1'b1);
                    end
                    if (burst_end) begin
                        state <= cache_pkg::st_idle;
                    end
                end
                default: begin
                end
            endcase

            // incrementing burst always starts at word 0
            if (rf.start) begin
                state        <= cache_pkg::st_refill;
                fill_tag     <= rf.line_tag;
                fill_index   <= rf.line_index;
                fill_way     <= rf.victim_way;
                victim_tag   <= rf.victim_tag;
                victim_dirty <= rf.victim_dirty;
                offset       <= '0;
                ready        <= '0;
            end
        end
    end

    // rdata holds the word that the fill write just replaced
    always_ff @(posedge clk) begin
        if (cap_en) begin
            victim_buf[cap_offset] <= fill_port.rdata;
        end
    end

    assign fill_port.en     = 1'b1;
    assign fill_port.strobe = {$bits(dbus_pkg::strobe_t){fill_write}};
    assign fill_port.pos    = {fill_way, fill_index, offset};
    assign fill_port.wdata  = mem_rdata;

    assign rf.avail     = state == cache_pkg::st_idle
                          || (state == cache_pkg::st_writeback && burst_end);
    assign rf.busy      = state != cache_pkg::st_idle;
    assign rf.cur_tag   = fill_tag;
    assign rf.cur_index = fill_index;
    assign rf.ready     = ready;

    assign mem_valid    = state != cache_pkg::st_idle;
    assign mem_is_write = state == cache_pkg::st_writeback;
    assign mem_addr     = {mem_is_write ? victim_tag : fill_tag, fill_index, {low_bits{1'b0}}};
    assign mem_wdata    = victim_buf[offset];

    // burst request holds until its last beat
    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !burst_end |=> mem_valid && $stable(mem_addr) && $stable(mem_is_write));

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     req,
    input  wire                     is_write,
    input  wire dbus_pkg::addr_t    addr,
    input  wire dbus_pkg::strobe_t  strobe,
    input  wire dbus_pkg::word_t    wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output dbus_pkg::word_t         rdata,
    output logic                    mem_valid,
    output logic                    mem_is_write,
    output dbus_pkg::addr_t         mem_addr,
    output dbus_pkg::word_t         mem_wdata,
    input  wire                     mem_okay,
    input  wire dbus_pkg::word_t    mem_rdata,
    input  wire                     mem_last
);
    refill_if   rf ();
    ram_port_if hit_port ();
    ram_port_if fill_port ();

    tag_lookup i_lookup (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .is_write (is_write),
        .addr     (addr),
        .strobe   (strobe),
        .wdata    (wdata),
        .addr_ok  (addr_ok),
        .rf       (rf.lookup),
        .hit_port (hit_port.user)
    );

    data_store i_store (
        .clk       (clk),
        .resetn    (resetn),
        .hit_port  (hit_port.ram),
        .fill_port (fill_port.ram)
    );

    miss_engine i_engine (
        .clk          (clk),
        .resetn       (resetn),
        .rf           (rf.engine),
        .fill_port    (fill_port.user),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_okay     (mem_okay),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last)
    );

    // read data comes back one cycle after the accepted hit
    assign data_ok = hit_port.rvalid;
    assign rdata   = hit_port.rdata;

endmodule

`default_nettype wire

// ==== sim/tb_mem_responder.sv ====
`default_nettype none

module tb_mem_responder (
    input  wire                     clk,
    input  wire                     mem_valid,
    input  wire                     mem_is_write,
    input  wire dbus_pkg::addr_t    mem_addr,
    input  wire dbus_pkg::word_t    mem_wdata,
    input  wire dbus_pkg::word_t    ref_mem [128],
    output logic                    mem_okay,
    output dbus_pkg::word_t         mem_rdata,
    output logic                    mem_last,
    output int                      error_count,
    output int                      read_bursts,
    output int                      write_bursts
);
    dbus_pkg::word_t    store [128];
    int                 errors = 0;
    int                 reads = 0;
    int                 writes = 0;
    int                 beat = 0;
    int                 wait_left = 0;
    int                 idx;
    dbus_pkg::addr_t    burst_addr;
    logic               burst_write;

    assign error_count  = errors;
    assign read_bursts  = reads;
    assign write_bursts = writes;

    function automatic int word_index(input dbus_pkg::addr_t a, input int b);
        return int'(a[8:4]) * 4 + b;
    endfunction

    // beats go out just after the edge
    initial begin
        mem_okay  = 1'b0;
        mem_rdata = '0;
        mem_last  = 1'b0;
        for (int i = 0; i < 128; i++) begin
            store[i] = dbus_pkg::word_t'(i) * 32'h9e37_79b1 ^ 32'h5a3c_0f96;
        end
        forever begin
            @(posedge clk);
            #1;
            mem_okay  = mem_valid && wait_left == 0;
            mem_last  = mem_okay && beat == 3;
            mem_rdata = (mem_okay && !mem_is_write) ? store[word_index(mem_addr, beat)] : '0;
        end
    end

    // completed beats are taken mid-cycle, where the bus is settled
    always @(negedge clk) begin
        if (mem_valid && mem_okay) begin
            idx = word_index(mem_addr, beat);
            if (beat == 0) begin
                burst_addr  = mem_addr;
                burst_write = mem_is_write;
                assert (mem_addr[3:0] == 4'd0 && mem_addr[31:9] == '0) else begin
                    $display("burst address %h is not line aligned or lies outside memory",
                             mem_addr);
                    errors++;
                end
            end
            assert (mem_addr == burst_addr) else begin
                $display("error at time %0t: mem_addr = %h, expected %h",
                         $time, mem_addr, burst_addr);
                errors++;
            end
            assert (mem_is_write == burst_write) else begin
                $display("error at time %0t: mem_is_write = %b, expected %b",
                         $time, mem_is_write, burst_write);
                errors++;
            end
            if (mem_is_write) begin
                // evicted line must match the model word for word
                assert (mem_wdata == ref_mem[idx]) else begin
                    $display("error at time %0t: mem_wdata = %h, expected %h",
                             $time, mem_wdata, ref_mem[idx]);
                    errors++;
                end
                store[idx] = mem_wdata;
            end
            wait_left = $urandom_range(0, 3);
            if (beat == 3) begin
                beat = 0;
                if (mem_is_write) begin
                    writes++;
                end else begin
                    reads++;
                end
            end else begin
                beat++;
            end
        end else if (mem_valid) begin
            if (wait_left > 0) begin
                wait_left--;
            end
        end else begin
            assert (beat == 0) else begin
                $display("memory request dropped before the fourth beat of a burst");
                errors++;
                beat = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
`default_nettype none

module tb_dcache;

    localparam int mem_words    = 128;
    localparam int random_ops   = 400;
    localparam int directed_ops = 14;
    // refill plus writeback, four beats each with up to three wait cycles, and slack
    localparam int miss_cycles  = 40;
    localparam int time_limit   = (random_ops + directed_ops + 2) * miss_cycles * 10;

    logic               clk = 1'b0;
    logic               resetn;
    logic               req;
    logic               is_write;
    dbus_pkg::addr_t    addr;
    dbus_pkg::strobe_t  strobe;
    dbus_pkg::word_t    wdata;
    logic               addr_ok;
    logic               data_ok;
    dbus_pkg::word_t    rdata;
    logic               mem_valid;
    logic               mem_is_write;
    dbus_pkg::addr_t    mem_addr;
    dbus_pkg::word_t    mem_wdata;
    logic               mem_okay;
    dbus_pkg::word_t    mem_rdata;
    logic               mem_last;

    dbus_pkg::word_t    model [mem_words];
    int                 check_errors;
    int                 protocol_errors = 0;
    int                 mem_errors;
    int                 read_bursts;
    int                 write_bursts;
    logic               accepted_last = 1'b0;

    always #5 clk = ~clk;

    dcache_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .req          (req),
        .is_write     (is_write),
        .addr         (addr),
        .strobe       (strobe),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_okay     (mem_okay),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last)
    );

    tb_mem_responder i_mem (
        .clk          (clk),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .ref_mem      (model),
        .mem_okay     (mem_okay),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last),
        .error_count  (mem_errors),
        .read_bursts  (read_bursts),
        .write_bursts (write_bursts)
    );

    function automatic dbus_pkg::word_t apply_strobe(input dbus_pkg::word_t old_word,
                                                     input dbus_pkg::word_t new_word,
                                                     input dbus_pkg::strobe_t mask);
        dbus_pkg::word_t keep;
        for (int b = 0; b < 4; b++) begin
            keep[8 * b +: 8] = {8{mask[b]}};
        end
        return (old_word & ~keep) | (new_word & keep);
    endfunction

    // data_ok exactly one cycle after each accepted request
    always @(negedge clk) begin
        assert (data_ok == accepted_last) else begin
            $display("error at time %0t: data_ok = %b, expected %b",
                     $time, data_ok, accepted_last);
            protocol_errors++;
        end
        accepted_last = addr_ok;
    end

    // one request, held until accepted, then data checked a cycle later
    task automatic access(input logic wr, input dbus_pkg::addr_t a,
                          input dbus_pkg::strobe_t s, input dbus_pkg::word_t d);
        int idx;
        dbus_pkg::word_t expected;
        idx = int'(a[8:2]);
        @(posedge clk);
        #1;
        req      = 1'b1;
        is_write = wr;
        addr     = a;
        strobe   = s;
        wdata    = d;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        expected = model[idx];
        if (wr) begin
            model[idx] = apply_strobe(model[idx], d, s);
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        if (!wr) begin
            assert (rdata == expected) else begin
                $display("error at time %0t: rdata = %h, expected %h", $time, rdata, expected);
                check_errors++;
            end
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (mem_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_bursts(input int exp_reads, input int exp_writes);
        assert (read_bursts == exp_reads) else begin
            $display("error at time %0t: read_bursts = %0d, expected %0d",
                     $time, read_bursts, exp_reads);
            check_errors++;
        end
        assert (write_bursts == exp_writes) else begin
            $display("error at time %0t: write_bursts = %0d, expected %0d",
                     $time, write_bursts, exp_writes);
            check_errors++;
        end
    endtask

    initial begin
        int reads_before;
        int writes_before;
        resetn       = 1'b1;
        req          = 1'b0;
        is_write     = 1'b0;
        addr         = '0;
        strobe       = '0;
        wdata        = '0;
        check_errors = 0;
        void'($urandom(30));
        for (int i = 0; i < mem_words; i++) begin
            model[i] = dbus_pkg::word_t'(i) * 32'h9e37_79b1 ^ 32'h5a3c_0f96;
        end
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b0;
        @(negedge clk);
        assert (!addr_ok && !data_ok && !mem_valid) else begin
            $display("addr_ok, data_ok or mem_valid is high right after reset");
            check_errors++;
        end

        // fresh line costs one read burst, the second read none
        access(1'b0, 32'h0000_0000, '0, '0);
        wait_idle();
        check_bursts(1, 0);
        access(1'b0, 32'h0000_000c, '0, '0);
        wait_idle();
        check_bursts(1, 0);

        // six tags written into set 1, the last two evict dirty lines
        reads_before  = read_bursts;
        writes_before = write_bursts;
        for (int t = 0; t < 6; t++) begin
            access(1'b1, {23'd0, 3'(t), 2'b01, 4'd0}, 4'hf, $urandom);
        end
        wait_idle();
        check_bursts(reads_before + 6, writes_before + 2);
        for (int t = 0; t < 6; t++) begin
            access(1'b0, {23'd0, 3'(t), 2'b01, 4'd0}, '0, '0);
        end

        for (int n = 0; n < random_ops; n++) begin
            access(1'($urandom_range(0, 1)),
                   dbus_pkg::addr_t'($urandom_range(0, mem_words - 1)) << 2,
                   dbus_pkg::strobe_t'($urandom_range(0, 15)), $urandom);
        end
        wait_idle();

        $display("error counts: checks %0d, protocol %0d, memory %0d",
                 check_errors, protocol_errors, mem_errors);
        if (check_errors == 0 && protocol_errors == 0 && mem_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(time_limit);
        $display("watchdog expired before all operations completed");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/dbus_pkg.sv
logic/cache_pkg.sv
logic/refill_if.sv
logic/ram_port_if.sv
logic/tag_lookup.sv
logic/data_store.sv
logic/miss_engine.sv
logic/dcache_top.sv
sim/tb_mem_responder.sv
sim/tb_dcache.sv

// ==== Makefile ====
TOP := tb_dcache

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
